//--- Bender.yml
package:
  name: mm_systolic

export_include_dirs:
  - .

sources:
  - mm_data_pkg.sv
  - mm_cmd_pkg.sv
  - mm_pe.sv
  - mm_systolic_array.sv
  - mm_operand_feeder.sv
  - mm_cmd_decode.sv
  - mm_result_drain.sv
  - mm_top.sv
  - target: test
    files:
      - tb_mm_top.sv

//--- mm_cmd_decode.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module mm_cmd_decode
    import mm_cmd_pkg::*, mm_data_pkg::*;
(
    input  logic         clk_buf,
    input  logic         sys_reset,
    input  logic         cmd_valid,
    input  mm_cmd_word_u cmd_word,
    output logic         cmd_credit,
    output logic         row_we,
    output logic         row_sel_b,
    output logic [1:0]   row_idx,
    output mm_row_t      row_data,
    output logic         run_start,
    input  logic         drain_done,
    output logic         busy,
    output logic         done
);

    localparam int DEPTH = `MM_CMD_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mm_cmd_word_u     queue_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             pop;
    logic             expect_data;
    mm_cmd_word_u     head;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // -------------------------------------------------------------------
    // Command queue
    // -------------------------------------------------------------------

    // Host only sends against a credit, so a push never finds it full
    always_ff @(posedge clk_buf) begin
        if (cmd_valid) begin
            queue_mem[wr_ptr] <= cmd_word;
        end
    end

    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({cmd_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    assign head = queue_mem[rd_ptr];

    // Nothing leaves the queue during a run
    assign pop        = (fill != '0) && !busy;
    assign cmd_credit = pop;

    // -------------------------------------------------------------------
    // Word decode and run state
    // -------------------------------------------------------------------
    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            expect_data <= 1'b0;
            row_we      <= 1'b0;
            row_sel_b   <= 1'b0;
            row_idx     <= '0;
            run_start   <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            row_we    <= 1'b0;
            run_start <= 1'b0;
            if (drain_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (pop) begin
                if (expect_data) begin
                    row_we      <= 1'b1;
                    expect_data <= 1'b0;
                end else begin
                    case (head.ctrl.opcode)
                        OP_LOAD_A, OP_LOAD_B: begin
                            expect_data <= 1'b1;
                            row_sel_b   <= (head.ctrl.opcode == OP_LOAD_B);
                            row_idx     <= head.ctrl.row;
                        end
                        OP_START: begin
                            run_start <= 1'b1;
                            busy      <= 1'b1;
                            done      <= 1'b0;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Row payload, same view the host packed it with
    always_ff @(posedge clk_buf) begin
        if (pop && expect_data) begin
            row_data <= head.elems;
        end
    end

endmodule

//--- mm_cmd_pkg.sv
`include "mm_config.svh"

package mm_cmd_pkg;

    import mm_data_pkg::*;

    // ---------------------------------------------------------------------
    // Host command format
    // ---------------------------------------------------------------------

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_LOAD_A = 2'd1,
        OP_LOAD_B = 2'd2,
        OP_START  = 2'd3
    } mm_opcode_e;

    // Header words go through ctrl, the data word after a load header
    // goes through elems
    typedef union packed {
        struct packed {
            logic [`MM_CMD_W-5:0] rsvd;
            logic [1:0]           row;
            mm_opcode_e           opcode;
        } ctrl;
        mm_row_t elems;
    } mm_cmd_word_u;

endpackage

//--- mm_config.svh
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// Array geometry and arithmetic widths
`define MM_DIM          4
`define MM_ELEM_W       8
`define MM_ACC_W        32

// One command word carries a full operand row
`define MM_CMD_W        (`MM_DIM * `MM_ELEM_W)

// Command queue entries, also the host's starting credit count
`define MM_CMD_DEPTH    2

// Result words the host can accept after reset
`define MM_RES_CREDITS  4

// Cycles after the last injection until the far corner cell is final
`define MM_FLUSH_CYCLES (2 * `MM_DIM - 1)

`endif

//--- mm_data_pkg.sv
`include "mm_config.svh"

package mm_data_pkg;

    // ---------------------------------------------------------------------
    // Arithmetic types of the array
    // ---------------------------------------------------------------------

    // Signed operand element
    typedef logic signed [`MM_ELEM_W-1:0] mm_elem_t;

    // Per-cell accumulator, wide enough for MM_DIM full products
    typedef logic signed [`MM_ACC_W-1:0] mm_acc_t;

    // One matrix row, element 0 in the low byte
    typedef mm_elem_t [`MM_DIM-1:0] mm_row_t;

endpackage

//--- mm_operand_feeder.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module mm_operand_feeder
    import mm_data_pkg::*;
(
    input  logic       clk_buf,
    input  logic       sys_reset,
    input  logic       row_we,
    input  logic       row_sel_b,
    input  logic [1:0] row_idx,
    input  mm_row_t    row_data,
    input  logic       run_start,
    output logic       clear,
    output mm_row_t    a_edge,
    output mm_row_t    b_edge,
    output logic       calc_done
);

    localparam int DIM        = `MM_DIM;
    localparam int INJ_CYCLES = 2 * DIM - 1;
    localparam int FLUSH      = `MM_FLUSH_CYCLES;
    localparam int INJ_W      = $clog2(INJ_CYCLES);
    localparam int FLUSH_W    = $clog2(FLUSH);

    mm_row_t              a_buf [DIM];
    mm_row_t              b_buf [DIM];
    logic                 inj_active;
    logic [INJ_W-1:0]     inj_cnt;
    logic                 flush_active;
    logic [FLUSH_W-1:0]   flush_cnt;

    // -------------------------------------------------------------------
    // Operand row buffers, kept across runs
    // -------------------------------------------------------------------
    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            for (int i = 0; i < DIM; i++) begin
                a_buf[i] <= '0;
                b_buf[i] <= '0;
            end
        end else if (row_we) begin
            if (row_sel_b) begin
                b_buf[row_idx] <= row_data;
            end else begin
                a_buf[row_idx] <= row_data;
            end
        end
    end

    // -------------------------------------------------------------------
    // Clear, then injection, then flush
    // -------------------------------------------------------------------
    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            clear        <= 1'b0;
            inj_active   <= 1'b0;
            inj_cnt      <= '0;
            flush_active <= 1'b0;
            flush_cnt    <= '0;
        end else begin
            clear <= run_start;
            if (clear) begin
                inj_active <= 1'b1;
                inj_cnt    <= '0;
            end else if (inj_active) begin
                if (inj_cnt == INJ_W'(INJ_CYCLES - 1)) begin
                    inj_active   <= 1'b0;
                    flush_active <= 1'b1;
                    flush_cnt    <= '0;
                end else begin
                    inj_cnt <= inj_cnt + 1'b1;
                end
            end
            if (flush_active) begin
                if (flush_cnt == FLUSH_W'(FLUSH - 1)) begin
                    flush_active <= 1'b0;
                end else begin
                    flush_cnt <= flush_cnt + 1'b1;
                end
            end
        end
    end

    assign calc_done = flush_active && (flush_cnt == FLUSH_W'(FLUSH - 1));

    // Diagonal skew; out-of-range indices give the zero bubbles
    always_comb begin
        int k;
        a_edge = '0;
        b_edge = '0;
        for (int i = 0; i < DIM; i++) begin
            k = int'(inj_cnt) - i;
            if (inj_active && k >= 0 && k < DIM) begin
                a_edge[i] = a_buf[i][k];
                b_edge[i] = b_buf[k][i];
            end
        end
    end

endmodule

//--- mm_pe.sv
`timescale 1ns/1ns

module mm_pe
    import mm_data_pkg::*;
(
    input  logic     clk_buf,
    input  logic     sys_reset,
    input  logic     clear,
    input  mm_elem_t a_in,
    input  mm_elem_t b_in,
    output mm_elem_t a_out,
    output mm_elem_t b_out,
    output mm_acc_t  acc
);

    mm_acc_t prod;

    // Operands widen to the accumulator before the multiply
    assign prod = mm_acc_t'(a_in) * mm_acc_t'(b_in);

    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            // a moves right, b moves down
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + prod;
        end
    end

endmodule

//--- mm_result_drain.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module mm_result_drain
    import mm_data_pkg::*;
(
    input  logic                          clk_buf,
    input  logic                          sys_reset,
    input  logic                          calc_done,
    input  mm_acc_t [`MM_DIM*`MM_DIM-1:0] c_flat,
    output logic                          res_valid,
    output mm_acc_t                       res_data,
    input  logic                          res_credit,
    output logic                          drain_done
);

    localparam int WORDS  = `MM_DIM * `MM_DIM;
    localparam int IDX_W  = $clog2(WORDS);
    localparam int CRED_W = $clog2(`MM_RES_CREDITS + 1);

    mm_acc_t           snap [WORDS];
    logic              draining;
    logic [IDX_W-1:0]  word_idx;
    logic [CRED_W-1:0] credits;
    logic              send;

    // A word goes out whenever one is pending and a credit is held
    assign send = draining && (credits != '0);

    // -------------------------------------------------------------------
    // Snapshot and output data
    // -------------------------------------------------------------------
    always_ff @(posedge clk_buf) begin
        if (calc_done) begin
            for (int i = 0; i < WORDS; i++) begin
                snap[i] <= c_flat[i];
            end
        end
        if (send) begin
            res_data <= snap[word_idx];
        end
    end

    // -------------------------------------------------------------------
    // Word index and credit count
    // -------------------------------------------------------------------
    always_ff @(posedge clk_buf or posedge sys_reset) begin
        if (sys_reset) begin
            draining   <= 1'b0;
            word_idx   <= '0;
            credits    <= CRED_W'(`MM_RES_CREDITS);
            res_valid  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            res_valid  <= send;
            drain_done <= 1'b0;
            if (calc_done) begin
                draining <= 1'b1;
                word_idx <= '0;
            end else if (send) begin
                // Last word ends the run
                if (word_idx == IDX_W'(WORDS - 1)) begin
                    draining   <= 1'b0;
                    drain_done <= 1'b1;
                end
                word_idx <= word_idx + 1'b1;
            end
            case ({send, res_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- mm_systolic_array.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module mm_systolic_array
    import mm_data_pkg::*;
(
    input  logic                                clk_buf,
    input  logic                                sys_reset,
    input  logic                                clear,
    input  mm_row_t                             a_edge,
    input  mm_row_t                             b_edge,
    output mm_acc_t [`MM_DIM*`MM_DIM-1:0]       c_flat
);

    localparam int DIM = `MM_DIM;

    // Horizontal links carry a, vertical links carry b
    mm_elem_t a_link [DIM][DIM+1];
    mm_elem_t b_link [DIM+1][DIM];

    genvar r;
    genvar c;

    // Left edge gets one element per row
    for (r = 0; r < DIM; r++) begin : g_a_edge
        assign a_link[r][0] = a_edge[r];
    end

    // Top edge gets one element per column
    for (c = 0; c < DIM; c++) begin : g_b_edge
        assign b_link[0][c] = b_edge[c];
    end

    // -------------------------------------------------------------------
    // Cell grid, results in row-major order
    // -------------------------------------------------------------------
    for (r = 0; r < DIM; r++) begin : g_row
        for (c = 0; c < DIM; c++) begin : g_col
            mm_pe u_pe (
                .clk_buf   (clk_buf),
                .sys_reset (sys_reset),
                .clear     (clear),
                .a_in      (a_link[r][c]),
                .b_in      (b_link[r][c]),
                .a_out     (a_link[r][c+1]),
                .b_out     (b_link[r+1][c]),
                .acc       (c_flat[r*DIM+c])
            );
        end
    end

endmodule

//--- mm_top.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module mm_top
    import mm_cmd_pkg::*, mm_data_pkg::*;
(
    input  logic         clk_buf,
    input  logic         sys_reset,
    input  logic         cmd_valid,
    input  mm_cmd_word_u cmd_word,
    output logic         cmd_credit,
    output logic         res_valid,
    output mm_acc_t      res_data,
    input  logic         res_credit,
    output logic         busy,
    output logic         done
);

    logic                          row_we;
    logic                          row_sel_b;
    logic [1:0]                    row_idx;
    mm_row_t                       row_data;
    logic                          run_start;
    logic                          drain_done;
    logic                          clear;
    logic                          calc_done;
    mm_row_t                       a_edge;
    mm_row_t                       b_edge;
    mm_acc_t [`MM_DIM*`MM_DIM-1:0] c_flat;

    // -------------------------------------------------------------------
    // Command decode
    // -------------------------------------------------------------------
    mm_cmd_decode u_cmd_decode (
        .clk_buf    (clk_buf),
        .sys_reset  (sys_reset),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_credit (cmd_credit),
        .row_we     (row_we),
        .row_sel_b  (row_sel_b),
        .row_idx    (row_idx),
        .row_data   (row_data),
        .run_start  (run_start),
        .drain_done (drain_done),
        .busy       (busy),
        .done       (done)
    );

    // -------------------------------------------------------------------
    // Execute
    // -------------------------------------------------------------------
    mm_operand_feeder u_feeder (
        .clk_buf   (clk_buf),
        .sys_reset (sys_reset),
        .row_we    (row_we),
        .row_sel_b (row_sel_b),
        .row_idx   (row_idx),
        .row_data  (row_data),
        .run_start (run_start),
        .clear     (clear),
        .a_edge    (a_edge),
        .b_edge    (b_edge),
        .calc_done (calc_done)
    );

    mm_systolic_array u_systolic (
        .clk_buf   (clk_buf),
        .sys_reset (sys_reset),
        .clear     (clear),
        .a_edge    (a_edge),
        .b_edge    (b_edge),
        .c_flat    (c_flat)
    );

    // -------------------------------------------------------------------
    // Result drain
    // -------------------------------------------------------------------
    mm_result_drain u_drain (
        .clk_buf    (clk_buf),
        .sys_reset  (sys_reset),
        .calc_done  (calc_done),
        .c_flat     (c_flat),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_credit (res_credit),
        .drain_done (drain_done)
    );

endmodule

//--- src.f
+incdir+.
mm_data_pkg.sv
mm_cmd_pkg.sv
mm_pe.sv
mm_systolic_array.sv
mm_operand_feeder.sv
mm_cmd_decode.sv
mm_result_drain.sv
mm_top.sv
tb_mm_top.sv

//--- tb_mm_top.sv
`timescale 1ns/1ns
`include "mm_config.svh"

module tb_mm_top
    import mm_cmd_pkg::*, mm_data_pkg::*;
();

    localparam int DIM        = `MM_DIM;
    localparam int WORDS      = `MM_DIM * `MM_DIM;
    localparam int WAIT_LIMIT = 1000;

    logic         clk_buf;
    logic         sys_reset;
    logic         cmd_valid;
    mm_cmd_word_u cmd_word;
    logic         cmd_credit;
    logic         res_valid;
    mm_acc_t      res_data;
    logic         res_credit;
    logic         busy;
    logic         done;

    logic [31:0]  lfsr_state = 32'h7753_61cc;
    int           model_a [DIM][DIM];
    int           model_b [DIM][DIM];
    int           exp_c [2][WORDS];
    int           res_q [$];
    int           cmd_sent = 0;
    int           cmd_returned = 0;
    int           words_recv = 0;
    int           res_returned = 0;
    int           hold = 0;
    bit           withhold = 1'b0;
    bit           timed_out = 1'b0;
    int           checks = 0;
    int           errors = 0;
    int           tests = 0;
    int           err_mark = 0;

    mm_top i_dut (
        .clk_buf    (clk_buf),
        .sys_reset  (sys_reset),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_credit (res_credit),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk_buf = 1'b0;
        forever #2 clk_buf = ~clk_buf;
    end

    // ------------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------------

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'hD000_0001;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic int random_element();
        logic [31:0]       bits;
        logic signed [7:0] e;
        bits = lfsr_bits(8);
        e = bits[7:0];
        return e;
    endfunction

    // Full signed products with C in row-major order
    task automatic compute_expected(input int slot);
        int sum;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sum = 0;
                for (int k = 0; k < DIM; k++) begin
                    sum += model_a[i][k] * model_b[k][j];
                end
                exp_c[slot][i*DIM+j] = sum;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Reporting helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR @%0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic close_test(input string name);
        tests++;
        $display("Test %0d %s: %s (%0d errors)", tests, name,
                 (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
        err_mark = errors;
    endtask

    // ------------------------------------------------------------------
    // Command driver that counts its own credits
    // ------------------------------------------------------------------
    always @(posedge clk_buf) begin
        if (!sys_reset && cmd_credit) begin
            cmd_returned++;
            checks++;
            assert (cmd_returned <= cmd_sent) else begin
                $display("Command credit came back for a word never sent at %0t ns", $time);
                errors++;
            end
        end
    end

    function automatic int cmd_avail();
        return `MM_CMD_DEPTH + cmd_returned - cmd_sent;
    endfunction

    // Called at a falling edge and returns at a falling edge
    task automatic send_word(input logic [31:0] w);
        int waited;
        waited = 0;
        while (cmd_avail() <= 0 && !timed_out) begin
            @(negedge clk_buf);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("no command credit came back");
            end
        end
        if (!timed_out) begin
            cmd_valid = 1'b1;
            cmd_word  = w;
            cmd_sent++;
            @(negedge clk_buf);
            cmd_valid = 1'b0;
        end
    endtask

    // Header word holds the opcode in bits 1:0 and the row in bits 3:2
    function automatic logic [31:0] header_word(input mm_opcode_e op, input int row);
        logic [1:0] r;
        r = row[1:0];
        return {28'd0, r, op};
    endfunction

    // Each random row goes into the model and then out as header and data word
    task automatic load_random(input bit sel_b);
        logic [31:0] w;
        for (int r = 0; r < DIM; r++) begin
            w = '0;
            for (int j = 0; j < DIM; j++) begin
                if (sel_b) begin
                    model_b[r][j] = random_element();
                    w[8*j +: 8] = model_b[r][j][7:0];
                end else begin
                    model_a[r][j] = random_element();
                    w[8*j +: 8] = model_a[r][j][7:0];
                end
            end
            send_word(header_word(sel_b ? OP_LOAD_B : OP_LOAD_A, r));
            send_word(w);
        end
    endtask

    // ------------------------------------------------------------------
    // Result collector with random credit return
    // ------------------------------------------------------------------
    initial begin
        res_credit = 1'b0;
        forever begin
            @(negedge clk_buf);
            if (sys_reset) begin
                res_credit = 1'b0;
            end else begin
                if (res_valid) begin
                    res_q.push_back(res_data);
                    words_recv++;
                    checks++;
                    assert (words_recv <= `MM_RES_CREDITS + res_returned) else begin
                        $display("Result word sent without a credit at %0t ns", $time);
                        errors++;
                    end
                end
                if (hold > 0) begin
                    res_credit = 1'b0;
                    hold--;
                end else if (words_recv > res_returned) begin
                    res_credit = 1'b1;
                    res_returned++;
                    hold = withhold ? int'(lfsr_bits(4)) : int'(lfsr_bits(2));
                end else begin
                    res_credit = 1'b0;
                end
            end
        end
    end

    // Sixteen words against one expected set and optionally the end flags
    task automatic compare_run_results(input int slot, input bit check_flags);
        int waited;
        int got;
        for (int n = 0; n < WORDS && !timed_out; n++) begin
            waited = 0;
            while (res_q.size() == 0 && !timed_out) begin
                @(negedge clk_buf);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("result word did not arrive");
                end
            end
            if (!timed_out) begin
                got = res_q.pop_front();
                check_value($sformatf("C[%0d][%0d]", n / DIM, n % DIM), got, exp_c[slot][n]);
            end
        end
        if (check_flags && !timed_out) begin
            waited = 0;
            while (!(done && !busy) && !timed_out) begin
                @(negedge clk_buf);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("run did not finish with done set");
                end
            end
            repeat (4) @(negedge clk_buf);
            check_value("done", done, 1);
            check_value("busy", busy, 0);
            check_value("extra result words", res_q.size(), 0);
        end
    endtask

    task automatic wait_credits_back();
        int waited;
        waited = 0;
        while (cmd_returned != cmd_sent && !timed_out) begin
            @(negedge clk_buf);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("a command word never earned its credit");
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic idle_after_reset();
        repeat (10) @(negedge clk_buf);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("res_valid", res_valid, 0);
        check_value("cmd_credit pulses", cmd_returned, 0);
        close_test("idle after reset");
    endtask

    task automatic first_product();
        load_random(1'b0);
        load_random(1'b1);
        compute_expected(0);
        send_word(header_word(OP_START, 0));
        compare_run_results(0, 1'b1);
        close_test("first product");
    endtask

    task automatic product_after_b_reload();
        load_random(1'b1);
        compute_expected(0);
        send_word(header_word(OP_START, 0));
        compare_run_results(0, 1'b1);
        close_test("reload of B only");
    endtask

    task automatic product_with_withheld_credits();
        withhold = 1'b1;
        load_random(1'b0);
        compute_expected(0);
        send_word(header_word(OP_START, 0));
        compare_run_results(0, 1'b1);
        withhold = 1'b0;
        close_test("withheld result credits");
    endtask

    // Loads sit in the queue until the running product is drained
    task automatic loads_queued_behind_run();
        compute_expected(0);
        send_word(header_word(OP_START, 0));
        load_random(1'b1);
        compute_expected(1);
        send_word(header_word(OP_START, 0));
        compare_run_results(0, 1'b0);
        compare_run_results(1, 1'b1);
        wait_credits_back();
        close_test("loads queued behind a run");
    endtask

    initial begin
        sys_reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        repeat (5) @(negedge clk_buf);
        sys_reset = 1'b0;

        idle_after_reset();
        if (!timed_out) begin
            first_product();
        end
        if (!timed_out) begin
            product_after_b_reload();
        end
        if (!timed_out) begin
            product_with_withheld_credits();
        end
        if (!timed_out) begin
            loads_queued_behind_run();
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
